// ==== include/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// program counter
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

`endif

// ==== rtl/corePkg.sv ====
package corePkg;

    // major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {
        ADD    = 3'b000,
        SUB    = 3'b001,
        AND    = 3'b010,
        SLT    = 3'b011, // signed
        PASS_B = 3'b110  // lui
    } aluOpT;

    typedef enum logic [2:0] {
        NONE = 3'b000, // R-type has no immediate
        I    = 3'b001,
        S    = 3'b010,
        B    = 3'b011,
        U    = 3'b100,
        J    = 3'b101
    } immTypeT;

endpackage

// ==== rtl/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf;
    corePkg::immTypeT immType;
    corePkg::aluOpT   aluOp;
    logic             memWrite;
    logic             regWrite;
    logic             aluSrcImm; // immediate as operand B
    logic             memToReg;
    logic             branchEq;
    logic             branchNe;
    logic             branchLt;
    logic             jal;
    logic             jalr;
    logic             srcAPc;    // pc as operand A

    modport decoder (
        output immType, aluOp, memWrite, regWrite, aluSrcImm, memToReg,
               branchEq, branchNe, branchLt, jal, jalr, srcAPc
    );

    modport datapath (
        input immType, aluOp, memWrite, regWrite, aluSrcImm, memToReg,
              branchEq, branchNe, branchLt, jal, jalr, srcAPc
    );
endinterface

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module controlUnit (
    input  logic [`XLEN-1:0] instruction,
    ctrlIf.decoder           ctrl
);
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi, jalr
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010; // lw, sw
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub

    corePkg::opcodeT opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    assign opcode = corePkg::opcodeT'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        // anything not matched below stays a no-op
        ctrl.immType   = corePkg::NONE;
        ctrl.aluOp     = corePkg::ADD;
        ctrl.memWrite  = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.branchEq  = 1'b0;
        ctrl.branchNe  = 1'b0;
        ctrl.branchLt  = 1'b0;
        ctrl.jal       = 1'b0;
        ctrl.jalr      = 1'b0;
        ctrl.srcAPc    = 1'b0;
        case (opcode)
            corePkg::LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.immType   = corePkg::I;
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memToReg  = 1'b1;
                end
            end
            corePkg::OP_IMM: begin
                if (funct3 == F3_ADD) begin // addi
                    ctrl.immType   = corePkg::I;
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
            end
            corePkg::STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.immType   = corePkg::S;
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
            end
            corePkg::OP: begin
                if (funct3 == F3_ADD && funct7 == F7_BASE) begin
                    ctrl.regWrite = 1'b1;
                end else if (funct3 == F3_ADD && funct7 == F7_ALT) begin
                    ctrl.aluOp    = corePkg::SUB;
                    ctrl.regWrite = 1'b1;
                end else if (funct3 == F3_SLT && funct7 == F7_BASE) begin
                    ctrl.aluOp    = corePkg::SLT;
                    ctrl.regWrite = 1'b1;
                end else if (funct3 == F3_AND && funct7 == F7_BASE) begin
                    ctrl.aluOp    = corePkg::AND;
                    ctrl.regWrite = 1'b1;
                end
            end
            corePkg::BRANCH: begin
                case (funct3)
                    F3_BEQ: begin
                        ctrl.immType  = corePkg::B;
                        ctrl.aluOp    = corePkg::SUB;
                        ctrl.branchEq = 1'b1;
                    end
                    F3_BNE: begin
                        ctrl.immType  = corePkg::B;
                        ctrl.aluOp    = corePkg::SUB;
                        ctrl.branchNe = 1'b1;
                    end
                    F3_BLT: begin
                        ctrl.immType  = corePkg::B;
                        ctrl.aluOp    = corePkg::SLT; // taken on result bit 0
                        ctrl.branchLt = 1'b1;
                    end
                    default: ;
                endcase
            end
            corePkg::JALR: begin
                if (funct3 == F3_ADD) begin
                    ctrl.immType   = corePkg::I;
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.jalr      = 1'b1;
                end
            end
            corePkg::JAL: begin
                ctrl.immType  = corePkg::J;
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
            end
            corePkg::LUI: begin
                ctrl.immType   = corePkg::U;
                ctrl.aluOp     = corePkg::PASS_B;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            corePkg::AUIPC: begin
                ctrl.immType   = corePkg::U;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.srcAPc    = 1'b1;
            end
            default: ;
        endcase
    end
endmodule

// ==== rtl/immDecoder.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module immDecoder (
    input  logic [`XLEN-1:0] instruction,
    ctrlIf.datapath          ctrl,
    output logic [`XLEN-1:0] imm
);
    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (ctrl.immType)
            corePkg::I: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            corePkg::S: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            corePkg::B: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            corePkg::U: begin
                imm = {instruction[31:12], 12'h000};
            end
            corePkg::J: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and no-op
            end
        endcase
    end
endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module registerFile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData,
    input  logic                   writeEnable,
    output logic [`XLEN-1:0]       readDataA,
    output logic [`XLEN-1:0]       readDataB
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 reads as zero whatever the array holds
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end
endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module alu (
    input  logic [`XLEN-1:0] srcA,
    input  logic [`XLEN-1:0] srcB,
    input  corePkg::aluOpT   op,
    output logic [`XLEN-1:0] result,
    output logic             zero
);
    always_comb begin
        case (op)
            corePkg::ADD: begin
                result = srcA + srcB;
            end
            corePkg::SUB: begin
                result = srcA - srcB;
            end
            corePkg::AND: begin
                result = srcA & srcB;
            end
            corePkg::SLT: begin
                result = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            end
            corePkg::PASS_B: begin
                result = srcB; // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);
endmodule

// ==== rtl/nextPcUnit.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module nextPcUnit (
    input  logic             clk,
    input  logic             reset,
    ctrlIf.datapath          ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    input  logic             aluZero,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] writeBackNonMem
);
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] nextPc;
    logic             condTaken;
    logic             taken;
    logic             isJump;

    assign pcPlus4   = pc + `PC_STEP;
    assign pcPlusImm = pc + imm;
    assign isJump    = ctrl.jal | ctrl.jalr;

    assign condTaken = (ctrl.branchEq & aluZero)
                     | (ctrl.branchNe & ~aluZero)
                     | (ctrl.branchLt & aluResult[0]); // slt result
    assign taken     = condTaken | isJump;

    // jalr clears bit 0 of rs1 + imm
    assign target = ctrl.jalr ? {aluResult[`XLEN-1:1], 1'b0} : pcPlusImm;
    assign nextPc = taken ? target : pcPlus4;

    assign writeBackNonMem = isJump ? pcPlus4 : aluResult; // link address

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end
endmodule

// ==== rtl/rvCore.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module rvCore (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] instruction,
    output logic             we,
    output logic [`XLEN-1:0] addressToMem,
    output logic [`XLEN-1:0] dataToMem,
    input  logic [`XLEN-1:0] dataFromMem
);
    ctrlIf ctrl ();

    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       srcA;
    logic [`XLEN-1:0]       srcB;
    logic [`XLEN-1:0]       aluResult;
    logic                   aluZero;
    logic [`XLEN-1:0]       writeBackNonMem;
    logic [`XLEN-1:0]       writeBack;
    logic                   regWriteEn;

    assign rs1Addr = instruction[19:15];
    assign rs2Addr = instruction[24:20];
    assign rdAddr  = instruction[11:7];

    assign srcA      = ctrl.srcAPc ? pc : rs1Data; // auipc
    assign srcB      = ctrl.aluSrcImm ? imm : rs2Data;
    assign writeBack = ctrl.memToReg ? dataFromMem : writeBackNonMem;
    assign regWriteEn = ctrl.regWrite & ~reset; // no register updates while in reset

    assign we           = ctrl.memWrite;
    assign addressToMem = aluResult;
    assign dataToMem    = rs2Data;

    controlUnit i_controlUnit (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    immDecoder i_immDecoder (
        .instruction (instruction),
        .ctrl        (ctrl),
        .imm         (imm)
    );

    registerFile i_registerFile (
        .clk         (clk),
        .readAddrA   (rs1Addr),
        .readAddrB   (rs2Addr),
        .writeAddr   (rdAddr),
        .writeData   (writeBack),
        .writeEnable (regWriteEn),
        .readDataA   (rs1Data),
        .readDataB   (rs2Data)
    );

    alu i_alu (
        .srcA   (srcA),
        .srcB   (srcB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    nextPcUnit i_nextPcUnit (
        .clk             (clk),
        .reset           (reset),
        .ctrl            (ctrl),
        .imm             (imm),
        .aluResult       (aluResult),
        .aluZero         (aluZero),
        .pc              (pc),
        .writeBackNonMem (writeBackNonMem)
    );
endmodule

// ==== bench/tbMemory.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module tbMemory (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] instruction,
    input  logic             we,
    input  logic [`XLEN-1:0] addressToMem,
    input  logic [`XLEN-1:0] dataToMem,
    output logic [`XLEN-1:0] dataFromMem,
    output logic             loaded,
    output logic             loadFailed
);
    localparam int ROM_WORDS   = 64;
    localparam int RAM_WORDS   = 128;
    localparam int MAX_RECORDS = 64;

    logic [`XLEN-1:0] rom [ROM_WORDS];
    logic [`XLEN-1:0] ram [RAM_WORDS];

    // expected stores picked up by the testbench top
    logic [`XLEN-1:0] expAddr [MAX_RECORDS];
    logic [`XLEN-1:0] expData [MAX_RECORDS];
    string            expName [MAX_RECORDS];
    int               expCount;
    int               progLength;
    integer           seed;

    assign instruction = reset ? '0 : rom[pc[7:2]]; // zero bus decodes as no-op
    assign dataFromMem = ram[addressToMem[8:2]];

    always @(posedge clk) begin
        if (we) begin
            ram[addressToMem[8:2]] <= dataToMem;
        end
    end

    initial begin
        int               fd;
        int               fields;
        int               k;
        string            line;
        string            tag;
        string            name;
        logic [`XLEN-1:0] word0;
        logic [`XLEN-1:0] word1;
        loaded     = 1'b0;
        loadFailed = 1'b0;
        expCount   = 0;
        progLength = 0;
        seed       = 32'h55e9_8588;
        for (k = 0; k < ROM_WORDS; k++) begin
            rom[k] = '0;
        end
        for (k = 0; k < RAM_WORDS; k++) begin
            ram[k] = $random(seed); // stale contents before the first store
        end
        fd = $fopen("bench/rvCore_testdata.txt", "r");
        if (fd == 0) begin
            loadFailed = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                tag    = "";
                fields = $sscanf(line, "%s %h %h %s", tag, word0, word1, name);
                if (tag == "P" && fields >= 2 && progLength < ROM_WORDS) begin
                    rom[progLength] = word0;
                    progLength++;
                end else if (tag == "E" && fields == 4 && expCount < MAX_RECORDS) begin
                    expAddr[expCount] = word0;
                    expData[expCount] = word1;
                    expName[expCount] = name;
                    expCount++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    end
endmodule

// ==== bench/tbRvCore.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module tbRvCore;
    localparam int               RESET_CYCLES = 5;
    localparam int               CLK_PERIOD   = 40;
    localparam logic [`XLEN-1:0] SELF_LOOP    = 32'h0000_006f; // jal x0, 0

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instruction;
    logic             we;
    logic [`XLEN-1:0] addressToMem;
    logic [`XLEN-1:0] dataToMem;
    logic [`XLEN-1:0] dataFromMem;
    logic             loaded;
    logic             loadFailed;
    logic             programDone;

    logic [`XLEN-1:0] expAddrQ [$];
    logic [`XLEN-1:0] expDataQ [$];
    string            expNameQ [$];

    rvCore i_dut (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .instruction  (instruction),
        .we           (we),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .dataFromMem  (dataFromMem)
    );

    tbMemory i_mem (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .instruction  (instruction),
        .we           (we),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .dataFromMem  (dataFromMem),
        .loaded       (loaded),
        .loadFailed   (loadFailed)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string testName, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // each retiring store consumes one expected record
    always @(posedge clk) begin : storeMonitor
        logic [`XLEN-1:0] wantAddr;
        logic [`XLEN-1:0] wantData;
        string            testName;
        if (we === 1'b1) begin
            if (expAddrQ.size() == 0) begin
                abortRun($sformatf("unexpected store to address %h after the last expected store",
                                   addressToMem));
            end else begin
                wantAddr = expAddrQ.pop_front();
                wantData = expDataQ.pop_front();
                testName = expNameQ.pop_front();
                checkValue({testName, " address"}, wantAddr, addressToMem);
                checkValue({testName, " data"}, wantData, dataToMem);
            end
        end
        if (!reset && instruction === SELF_LOOP) begin
            programDone = 1'b1;
        end
    end

    initial begin
        int k;
        clk         = 1'b0;
        reset       = 1'b1;
        programDone = 1'b0;
        wait (loaded);
        if (loadFailed || i_mem.progLength == 0 || i_mem.expCount == 0) begin
            abortRun("the test data file is missing or holds no program or no expected stores");
        end
        for (k = 0; k < i_mem.expCount; k++) begin
            expAddrQ.push_back(i_mem.expAddr[k]);
            expDataQ.push_back(i_mem.expData[k]);
            expNameQ.push_back(i_mem.expName[k]);
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #2;
            checkValue("reset pc", `RESET_PC, pc);
            checkValue("reset we", '0, we);
        end
        reset = 1'b0;
        @(posedge clk);
        #2;
        checkValue("pc after first fetch", `RESET_PC + `PC_STEP, pc); // addi at the reset pc
        wait (programDone);
        if (expAddrQ.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abortRun($sformatf("program reached its final loop with %0d expected stores missing",
                               expAddrQ.size()));
        end
    end

    // watchdog scaled to the program length
    initial begin
        int cycleLimit;
        wait (loaded);
        cycleLimit = i_mem.progLength * 4 + 50;
        #(cycleLimit * CLK_PERIOD);
        abortRun("timeout: the expected stores never completed");
    end
endmodule

// ==== bench/rvCore_testdata.txt ====
# P <instruction word>, program in address order from 0
# E <store address> <store data> <test name>, expected stores in program order
P 00600093 # 00 addi x1, x0, 6
P ffd00113 # 04 addi x2, x0, -3
P 002081b3 # 08 add x3, x1, x2
P 10302023 # 0c sw x3, 0x100(x0)
P 40110233 # 10 sub x4, x2, x1
P 10402223 # 14 sw x4, 0x104(x0)
P 0020f2b3 # 18 and x5, x1, x2
P 10502423 # 1c sw x5, 0x108(x0)
P 00112333 # 20 slt x6, x2, x1
P 10602623 # 24 sw x6, 0x10c(x0)
P 0020a3b3 # 28 slt x7, x1, x2
P 10702823 # 2c sw x7, 0x110(x0)
P 10402403 # 30 lw x8, 0x104(x0)
P 10802a23 # 34 sw x8, 0x114(x0)
P 00708013 # 38 addi x0, x1, 7
P 10002c23 # 3c sw x0, 0x118(x0)
P 00108463 # 40 beq x1, x1, +8
P 1e102823 # 44 sw x1, 0x1f0(x0) poison
P 10102e23 # 48 sw x1, 0x11c(x0)
P 00208463 # 4c beq x1, x2, +8
P 12202023 # 50 sw x2, 0x120(x0)
P 00209463 # 54 bne x1, x2, +8
P 1e102823 # 58 sw x1, 0x1f0(x0) poison
P 12302223 # 5c sw x3, 0x124(x0)
P 00109463 # 60 bne x1, x1, +8
P 12402423 # 64 sw x4, 0x128(x0)
P 00114463 # 68 blt x2, x1, +8
P 1e102823 # 6c sw x1, 0x1f0(x0) poison
P 12502623 # 70 sw x5, 0x12c(x0)
P 0020c463 # 74 blt x1, x2, +8
P 12602823 # 78 sw x6, 0x130(x0)
P 008004ef # 7c jal x9, +8
P 1e102823 # 80 sw x1, 0x1f0(x0) poison
P 12902a23 # 84 sw x9, 0x134(x0)
P 00000597 # 88 auipc x11, 0
P 00c58667 # 8c jalr x12, 12(x11)
P 1e102823 # 90 sw x1, 0x1f0(x0) poison
P 12c02c23 # 94 sw x12, 0x138(x0)
P abcde6b7 # 98 lui x13, 0xabcde
P 12d02e23 # 9c sw x13, 0x13c(x0)
P 12345717 # a0 auipc x14, 0x12345
P 14e02023 # a4 sw x14, 0x140(x0)
P 0000006f # a8 jal x0, 0
E 00000100 00000003 add
E 00000104 fffffff7 sub
E 00000108 00000004 and
E 0000010c 00000001 slt_neg_lt
E 00000110 00000000 slt_pos_ge
E 00000114 fffffff7 lw_roundtrip
E 00000118 00000000 x0_discard
E 0000011c 00000006 beq_taken
E 00000120 fffffffd beq_not_taken
E 00000124 00000003 bne_taken
E 00000128 fffffff7 bne_not_taken
E 0000012c 00000004 blt_taken
E 00000130 00000001 blt_not_taken
E 00000134 00000080 jal_link
E 00000138 00000090 jalr_link
E 0000013c abcde000 lui
E 00000140 123450a0 auipc

// ==== all.f ====
+incdir+include
rtl/corePkg.sv
rtl/ctrlIf.sv
rtl/controlUnit.sv
rtl/immDecoder.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/nextPcUnit.sv
rtl/rvCore.sv
bench/tbMemory.sv
bench/tbRvCore.sv
